/* run_sim.sh */
#!/usr/bin/env bash
# build the rv_lsu testbench with verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f rv_lsu.f \
    --top-module tb_rv_lsu -o sim_rv_lsu \
    && ./obj_dir/sim_rv_lsu | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* rv_lsu.f */
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/lsu_types_pkg.sv
verilog/lsu_ifs.sv
verilog/mem_decode.sv
verilog/lsu_execute.sv
verilog/data_ram.sv
verilog/load_result.sv
verilog/rv_lsu_top.sv
testbench/tb_rv_lsu.sv

/* testbench/rv_lsu_stim.txt */
# P idx value : preload register idx with value (hex)
# I or B inst kind a b : kind W = write-back of reg a with b, F = fault cause a, N = none
# B issues the next record on the very next cycle, I adds a random gap
P 01 00000100
P 02 DEADBEEF
P 03 00000180
P 04 000000A5
P 05 00008ABC
P 06 12345678
# word round trip, load right behind the store
B 0020A023 N 00 00000000
I 0000A503 W 0a DEADBEEF
I 0060A223 N 00 00000000
# byte and halfword lanes
I 004080A3 N 00 00000000
I 004081A3 N 00 00000000
I 0000A603 W 0c A5ADA5EF
I 00509323 N 00 00000000
I 00408223 N 00 00000000
I 0040A683 W 0d 8ABC56A5
I 0020A423 N 00 00000000
I 00408523 N 00 00000000
I 00509423 N 00 00000000
I 0080A703 W 0e DEA58ABC
# load extension
I 00008783 W 0f FFFFFFEF
I 0000C803 W 10 000000EF
I 00209883 W 11 FFFFA5AD
I 0020D903 W 12 0000A5AD
# address generation, negative offset, x0 base, x0 destination
I F881AA03 W 14 DEA58ABC
I 10402A83 W 15 8ABC56A5
I 0000A003 N 00 00000000
B FE61AE23 N 00 00000000
I 17C02B03 W 16 12345678
# faults
I 00109B83 F 02 00000000
I 0020AC03 F 02 00000000
I 006090A3 F 02 00000000
I 0060A123 F 02 00000000
I 0000AC83 W 19 A5ADA5EF
I 00108093 F 01 00000000
# back-to-back burst
B 0040AD03 W 1a 8ABC56A5
B 0030DD83 F 02 00000000
B 0030CE03 W 1c 000000A5
I 0080AE83 W 1d DEA58ABC

/* testbench/tb_rv_lsu.sv */
`timescale 1ns/1ps
`include "lsu_config.svh"

module tb_rv_lsu import lsu_types_pkg::*; ();

    logic         clk;
    logic         rst;
    logic         inst_valid;
    word_t        inst;
    logic         preload_en;
    reg_idx_t     preload_idx;
    word_t        preload_data;
    logic         wb_valid;
    reg_idx_t     wb_rd;
    word_t        wb_data;
    logic         fault_valid;
    fault_cause_e fault_cause;

    // one outcome, due at a numbered rising edge
    typedef struct packed {
        logic [31:0] due;
        logic [7:0]  kind;
        word_t       a;
        word_t       b;
    } expect_t;

    expect_t     pending[$];
    // stimulus records, in file order
    logic [7:0]  rec_tag[$];
    logic [7:0]  rec_kind[$];
    word_t       rec_x[$];
    word_t       rec_a[$];
    word_t       rec_b[$];
    logic [31:0] edge_no = '0;
    bit          stim_ready = 1'b0;

    rv_lsu_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // rising edge count, read only on falling edges
    always @(posedge clk) begin
        edge_no <= edge_no + 1;
    end

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_value(string name, word_t actual, word_t expected);
        if (actual !== expected) begin
            $display("MISMATCH time=%0t signal=%s actual=%h expected=%h",
                     $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic read_stim();
        int             fd;
        int             n;
        logic [7:0]     tag;
        logic [7:0]     kind;
        word_t          x;
        word_t          a;
        word_t          b;
        logic [1023:0]  rest;
        fd = $fopen("testbench/rv_lsu_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file");
            abort_run();
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                // comment, drop the rest of the line
                n = $fgets(rest, fd);
            end else begin
                if (tag == "P") begin
                    n = $fscanf(fd, "%h %h", x, a) + 2;
                    kind = "N";
                    b = '0;
                end else begin
                    n = $fscanf(fd, "%h %s %h %h", x, kind, a, b);
                end
                if (n != 4 || !(tag inside {"P", "I", "B"})) begin
                    $display("bad record in the stimulus file");
                    abort_run();
                end
                rec_tag.push_back(tag);
                rec_kind.push_back(kind);
                rec_x.push_back(x);
                rec_a.push_back(a);
                rec_b.push_back(b);
            end
        end
        $fclose(fd);
    endtask

    // outcomes land exactly LSU_LATENCY edges after issue, nothing in between
    always @(negedge clk) begin
        if (!rst) begin
            if (pending.size() != 0 && pending[0].due == edge_no) begin
                if (pending[0].kind == "W") begin
                    check_value("wb_valid", word_t'(wb_valid), 1);
                    check_value("fault_valid", word_t'(fault_valid), 0);
                    check_value("wb_rd", word_t'(wb_rd), pending[0].a);
                    check_value("wb_data", wb_data, pending[0].b);
                end else begin
                    check_value("fault_valid", word_t'(fault_valid), 1);
                    check_value("wb_valid", word_t'(wb_valid), 0);
                    check_value("fault_cause", word_t'(fault_cause), pending[0].a);
                end
                void'(pending.pop_front());
            end else begin
                check_value("wb_valid", word_t'(wb_valid), 0);
                check_value("fault_valid", word_t'(fault_valid), 0);
            end
        end
    end

    // budget of 8 cycles per record plus slack
    initial begin
        wait (stim_ready);
        #(rec_tag.size() * 8 * 10 + 500);
        $display("timeout, the run did not finish in time");
        abort_run();
    end

    initial begin
        int gap;
        void'($urandom(22065));
        rst          = 1'b1;
        inst_valid   = 1'b0;
        inst         = '0;
        preload_en   = 1'b0;
        preload_idx  = '0;
        preload_data = '0;
        read_stim();
        stim_ready = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // strobes quiet out of reset
        check_value("wb_valid", word_t'(wb_valid), 0);
        check_value("fault_valid", word_t'(fault_valid), 0);
        foreach (rec_tag[i]) begin
            if (rec_tag[i] == "P") begin
                // let in-flight ops retire before touching the regfile
                repeat (`LSU_LATENCY + 1) @(negedge clk);
                preload_en   = 1'b1;
                preload_idx  = rec_x[i][4:0];
                preload_data = rec_a[i];
                @(negedge clk);
                preload_en = 1'b0;
            end else begin
                inst_valid = 1'b1;
                inst       = rec_x[i];
                // sampled at the next edge, outcome LSU_LATENCY edges later
                if (rec_kind[i] != "N") begin
                    pending.push_back('{edge_no + 1 + `LSU_LATENCY,
                                        rec_kind[i], rec_a[i], rec_b[i]});
                end
                @(negedge clk);
                inst_valid = 1'b0;
                gap = (rec_tag[i] == "B") ? 0 : int'($urandom % 5);
                repeat (gap) @(negedge clk);
            end
        end
        repeat (`LSU_LATENCY + 2) @(negedge clk);
        if (pending.size() == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("%0d expected outcomes never appeared", pending.size());
            abort_run();
        end
    end

endmodule

/* verilog/data_ram.sv */
`timescale 1ns/1ps

module data_ram import lsu_types_pkg::*; (
    input  logic      clk,
    ram_port_if.slave ram,
    output word_t     rdata
);

    // depth follows the index type
    localparam int unsigned DEPTH = 1 << $bits(ram_idx_t);

    word_t mem [DEPTH];

    // masked write, one byte lane at a time
    always_ff @(posedge clk) begin
        if (ram.en && ram.we) begin
            for (int i = 0; i < 4; i++) begin
                if (ram.wmask[i]) begin
                    mem[ram.word_idx][8*i +: 8] <= ram.wdata[8*i +: 8];
                end
            end
        end
    end

    // registered read
    // holds the last word when idle or writing
    always_ff @(posedge clk) begin
        if (ram.en && !ram.we) begin
            rdata <= mem[ram.word_idx];
        end
    end

endmodule

/* verilog/load_result.sv */
`timescale 1ns/1ps
`include "lsu_config.svh"

module load_result import rv_isa_pkg::*, lsu_types_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    exec_to_result_if.consumer from_exec,
    input  word_t              rdata,
    reg_read_if.owner          regs,
    input  logic               preload_en,
    input  reg_idx_t           preload_idx,
    input  word_t              preload_data,
    output logic               wb_valid,
    output reg_idx_t           wb_rd,
    output word_t              wb_data,
    output logic               fault_valid,
    output fault_cause_e       fault_cause
);

    word_t       rf [`LSU_REG_COUNT];
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    word_t       load_val;
    logic        wb_write;
    logic        fault_d;

    // x0 is hardwired
    assign regs.rs1_data = (regs.rs1_idx == '0) ? '0 : rf[regs.rs1_idx];
    assign regs.rs2_data = (regs.rs2_idx == '0) ? '0 : rf[regs.rs2_idx];

    // lane pick
    assign byte_sel = rdata[{from_exec.lane, 3'b000} +: 8];
    // halfword lane is aligned, so only lane[1] matters
    assign half_sel = rdata[{from_exec.lane[1], 4'b0000} +: 16];

    // sign or zero extension
    always_comb begin
        case (from_exec.op)
            MOP_LB:  load_val = {{24{byte_sel[7]}}, byte_sel};
            MOP_LBU: load_val = {24'b0, byte_sel};
            MOP_LH:  load_val = {{16{half_sel[15]}}, half_sel};
            MOP_LHU: load_val = {16'b0, half_sel};
            MOP_LW:  load_val = rdata;
            default: load_val = '0;
        endcase
    end

    assign fault_d = from_exec.valid && (from_exec.cause != FC_NONE);

    // good load with a real destination
    assign wb_write = from_exec.valid && (from_exec.cause == FC_NONE)
                      && op_is_load(from_exec.op) && (from_exec.rd != '0);

    // register file
    // preload beats write-back
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `LSU_REG_COUNT; i++) begin
                rf[i] <= '0;
            end
        end else if (preload_en) begin
            if (preload_idx != '0) begin
                rf[preload_idx] <= preload_data;
            end
        end else if (wb_write) begin
            rf[from_exec.rd] <= load_val;
        end
    end

    // outcome strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid    <= 1'b0;
            fault_valid <= 1'b0;
        end else begin
            wb_valid    <= wb_write;
            fault_valid <= fault_d;
        end
    end

    // outcome payload
    always_ff @(posedge clk) begin
        wb_rd       <= from_exec.rd;
        wb_data     <= load_val;
        fault_cause <= from_exec.cause;
    end

    a_one_outcome: assert property (@(posedge clk) disable iff (rst)
        !(wb_valid && fault_valid));

endmodule

/* verilog/lsu_config.svh */
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// integer register file size
`define LSU_REG_COUNT 32

// data ram depth in words, as log2
`define LSU_RAM_WORDS_LOG2 8

// edges from instruction sample to write-back or fault
`define LSU_LATENCY 3

`endif

/* verilog/lsu_execute.sv */
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_execute import rv_isa_pkg::*, lsu_types_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    mem_op_if.consumer         op_in,
    reg_read_if.reader         regs,
    ram_port_if.master         ram,
    exec_to_result_if.producer to_result
);

    addr_t        addr;
    lane_sel_t    lane;
    logic         misaligned;
    fault_cause_e cause_d;
    logic         access_d;
    byte_mask_t   wmask_d;
    word_t        wdata_d;

    // first stage of side information, beside the ram request
    logic         s1_valid;
    mem_op_e      s1_op;
    reg_idx_t     s1_rd;
    lane_sel_t    s1_lane;
    fault_cause_e s1_cause;

    // operand read
    assign regs.rs1_idx = op_in.rs1;
    assign regs.rs2_idx = op_in.rs2;

    // effective address
    assign addr = regs.rs1_data + op_in.imm;
    assign lane = addr[1:0];

    // natural alignment per access width
    always_comb begin
        case (op_in.op)
            MOP_LH, MOP_LHU, MOP_SH: misaligned = addr[0];
            MOP_LW, MOP_SW:          misaligned = (addr[1:0] != 2'b00);
            default:                 misaligned = 1'b0;
        endcase
    end

    // illegal wins over misaligned
    always_comb begin
        if (op_in.illegal) begin
            cause_d = FC_ILLEGAL;
        end else if (misaligned) begin
            cause_d = FC_MISALIGNED;
        end else begin
            cause_d = FC_NONE;
        end
    end

    // faulting ops never touch the ram
    assign access_d = op_in.valid && (cause_d == FC_NONE);

    // store lane steering
    assign wdata_d = regs.rs2_data << {lane, 3'b000};

    always_comb begin
        case (op_in.op)
            MOP_SB:  wmask_d = byte_mask_t'(4'b0001 << lane);
            MOP_SH:  wmask_d = byte_mask_t'(4'b0011 << lane);
            MOP_SW:  wmask_d = 4'b1111;
            // loads write nothing
            default: wmask_d = 4'b0000;
        endcase
    end

    // control flops
    always_ff @(posedge clk) begin
        if (rst) begin
            ram.en          <= 1'b0;
            ram.we          <= 1'b0;
            s1_valid        <= 1'b0;
            to_result.valid <= 1'b0;
        end else begin
            ram.en          <= access_d;
            ram.we          <= access_d && op_is_store(op_in.op);
            s1_valid        <= op_in.valid;
            to_result.valid <= s1_valid;
        end
    end

    // ram request payload
    always_ff @(posedge clk) begin
        ram.word_idx <= addr[`LSU_RAM_WORDS_LOG2+1:2];
        ram.wmask    <= wmask_d;
        ram.wdata    <= wdata_d;
    end

    // side information, two stages to meet the ram read data
    always_ff @(posedge clk) begin
        s1_op           <= op_in.op;
        s1_rd           <= op_in.rd;
        s1_lane         <= lane;
        s1_cause        <= cause_d;
        to_result.op    <= s1_op;
        to_result.rd    <= s1_rd;
        to_result.lane  <= s1_lane;
        to_result.cause <= s1_cause;
    end

    a_we_needs_en: assert property (@(posedge clk) disable iff (rst)
        ram.we |-> ram.en);

    a_write_mask: assert property (@(posedge clk) disable iff (rst)
        ram.we |-> ram.wmask != '0);

endmodule

/* verilog/lsu_ifs.sv */
`timescale 1ns/1ps

// decoded instruction, decode to execute
interface mem_op_if import rv_isa_pkg::*, lsu_types_pkg::*; ();
    logic     valid;
    mem_op_e  op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;
    logic     illegal;

    modport producer (output valid, op, rd, rs1, rs2, imm, illegal);
    modport consumer (input valid, op, rd, rs1, rs2, imm, illegal);
endinterface

// combinational register file read, two ports
interface reg_read_if import lsu_types_pkg::*; ();
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_data;
    word_t    rs2_data;

    modport reader (output rs1_idx, rs2_idx, input rs1_data, rs2_data);
    modport owner (input rs1_idx, rs2_idx, output rs1_data, rs2_data);
endinterface

// data ram request
// read data comes back on a separate port one cycle later
interface ram_port_if import lsu_types_pkg::*; ();
    logic       en;
    logic       we;
    ram_idx_t   word_idx;
    byte_mask_t wmask;
    word_t      wdata;

    modport master (output en, we, word_idx, wmask, wdata);
    modport slave (input en, we, word_idx, wmask, wdata);
endinterface

// side information lined up with ram read data
interface exec_to_result_if import rv_isa_pkg::*, lsu_types_pkg::*; ();
    logic         valid;
    mem_op_e      op;
    reg_idx_t     rd;
    lane_sel_t    lane;
    fault_cause_e cause;

    modport producer (output valid, op, rd, lane, cause);
    modport consumer (input valid, op, rd, lane, cause);
endinterface

/* verilog/lsu_types_pkg.sv */
`include "lsu_config.svh"

package lsu_types_pkg;

    // data word and byte address
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // architectural register number
    typedef logic [4:0] reg_idx_t;

    // one bit per byte lane of a word
    typedef logic [3:0] byte_mask_t;

    // byte offset inside a word, addr[1:0]
    typedef logic [1:0] lane_sel_t;

    // word index into the data ram
    typedef logic [`LSU_RAM_WORDS_LOG2-1:0] ram_idx_t;

    // why an instruction took no effect
    typedef enum logic [1:0] {
        FC_NONE,
        FC_ILLEGAL,
        FC_MISALIGNED
    } fault_cause_e;

endpackage

/* verilog/mem_decode.sv */
`timescale 1ns/1ps

module mem_decode import rv_isa_pkg::*, lsu_types_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       inst_valid,
    input  word_t      inst,
    mem_op_if.producer op_out
);

    opcode_t opcode;
    funct3_t funct3;
    mem_op_e op_d;
    word_t   imm_i;
    word_t   imm_s;

    // instruction fields
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    // i-type immediate for loads
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    // s-type immediate for stores, split field
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};

    always_comb begin
        op_d = MOP_NONE;
        case (opcode)
            OPC_LOAD: begin
                case (funct3)
                    F3_B:    op_d = MOP_LB;
                    F3_H:    op_d = MOP_LH;
                    F3_W:    op_d = MOP_LW;
                    F3_BU:   op_d = MOP_LBU;
                    F3_HU:   op_d = MOP_LHU;
                    default: op_d = MOP_NONE;
                endcase
            end
            OPC_STORE: begin
                // no unsigned forms for stores
                case (funct3)
                    F3_B:    op_d = MOP_SB;
                    F3_H:    op_d = MOP_SH;
                    F3_W:    op_d = MOP_SW;
                    default: op_d = MOP_NONE;
                endcase
            end
            default: op_d = MOP_NONE;
        endcase
    end

    // strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            op_out.valid <= 1'b0;
        end else begin
            op_out.valid <= inst_valid;
        end
    end

    // fields held alongside valid
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            op_out.op      <= op_d;
            op_out.illegal <= (op_d == MOP_NONE);
            op_out.rs1     <= inst[19:15];
            op_out.rs2     <= inst[24:20];
            // stores have no destination
            op_out.rd      <= op_is_store(op_d) ? reg_idx_t'(0) : inst[11:7];
            op_out.imm     <= op_is_store(op_d) ? imm_s : imm_i;
        end
    end

    // a legal instruction always carries a memory op
    a_legal_has_op: assert property (@(posedge clk) disable iff (rst)
        op_out.valid && !op_out.illegal |-> op_out.op != MOP_NONE);

endmodule

/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

    // major opcode field, inst[6:0]
    typedef logic [6:0] opcode_t;

    // width select field, inst[14:12]
    typedef logic [2:0] funct3_t;

    localparam opcode_t OPC_LOAD  = 7'b0000011;
    localparam opcode_t OPC_STORE = 7'b0100011;

    // funct3 encodings shared by loads and stores
    localparam funct3_t F3_B  = 3'b000;
    localparam funct3_t F3_H  = 3'b001;
    localparam funct3_t F3_W  = 3'b010;
    localparam funct3_t F3_BU = 3'b100;
    localparam funct3_t F3_HU = 3'b101;

    // decoded memory operation
    typedef enum logic [3:0] {
        MOP_NONE,
        MOP_LB,
        MOP_LBU,
        MOP_LH,
        MOP_LHU,
        MOP_LW,
        MOP_SB,
        MOP_SH,
        MOP_SW
    } mem_op_e;

    function automatic logic op_is_load(mem_op_e op);
        return op inside {MOP_LB, MOP_LBU, MOP_LH, MOP_LHU, MOP_LW};
    endfunction

    function automatic logic op_is_store(mem_op_e op);
        return op inside {MOP_SB, MOP_SH, MOP_SW};
    endfunction

endpackage

/* verilog/rv_lsu_top.sv */
`timescale 1ns/1ps

module rv_lsu_top import lsu_types_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         inst_valid,
    input  word_t        inst,
    input  logic         preload_en,
    input  reg_idx_t     preload_idx,
    input  word_t        preload_data,
    output logic         wb_valid,
    output reg_idx_t     wb_rd,
    output word_t        wb_data,
    output logic         fault_valid,
    output fault_cause_e fault_cause
);

    mem_op_if         op_bus ();
    reg_read_if       rd_bus ();
    ram_port_if       ram_bus ();
    exec_to_result_if res_bus ();

    // ram read data back to the result stage
    word_t ram_rdata;

    mem_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .op_out     (op_bus.producer)
    );

    lsu_execute u_execute (
        .clk       (clk),
        .rst       (rst),
        .op_in     (op_bus.consumer),
        .regs      (rd_bus.reader),
        .ram       (ram_bus.master),
        .to_result (res_bus.producer)
    );

    data_ram u_ram (
        .clk   (clk),
        .ram   (ram_bus.slave),
        .rdata (ram_rdata)
    );

    load_result u_result (
        .clk          (clk),
        .rst          (rst),
        .from_exec    (res_bus.consumer),
        .rdata        (ram_rdata),
        .regs         (rd_bus.owner),
        .preload_en   (preload_en),
        .preload_idx  (preload_idx),
        .preload_data (preload_data),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .fault_valid  (fault_valid),
        .fault_cause  (fault_cause)
    );

endmodule
